// ==== include/dma_ctrl_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma sequencer constants
// engine register map, local window, widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DMA_CTRL_CONSTS_SVH
`define DMA_CTRL_CONSTS_SVH

// engine register offsets
`define DMA_CTRL_OFS        6'h00
`define DMA_MASK_OFS        6'h04
`define DMA_STATUS_OFS      6'h0C
`define DMA_RD_ADDR_OFS     6'h10
`define DMA_WR_ADDR_OFS     6'h20
`define DMA_BTT_OFS         6'h30

`define DMA_LOCAL_WINDOW    32'h0004_0000 // local sram as seen by the engine
`define DMA_ELEM_BYTES      2
`define DMA_MAX_OUTSTANDING 4             // write responses in flight

// widths
`define DMA_OFS_W           6
`define DMA_ADDR_W          32
`define DMA_DATA_W          32
`define DMA_STRB_W          4
`define DMA_STEP_W          24
`define DMA_RESP_CNT_W      3

`endif

// ==== design/dma_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma sequencer types
// bus vectors, walk widths, sequencer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_ctrl_consts.svh"

package dma_ctrl_pkg;

    typedef logic [`DMA_OFS_W-1:0]      reg_ofs_t;   // engine register offset
    typedef logic [`DMA_ADDR_W-1:0]     axil_addr_t;
    typedef logic [`DMA_DATA_W-1:0]     axil_data_t;
    typedef logic [`DMA_STEP_W-1:0]     step_t;      // steps, limits, counts
    typedef logic [`DMA_RESP_CNT_W-1:0] resp_cnt_t;

    // per-chunk command sequence
    typedef enum logic [3:0] {
        IDLE,
        SEND_SETUP,      // mask, btt, reader and writer addresses
        SYNC_WRESP,
        SEND_START,
        WAIT_START_RESP,
        WAIT_INTR,
        SEND_CLEAR,
        WAIT_CLEAR_RESP,
        NEXT_CHUNK
    } seq_state_t;

endpackage

// ==== design/axil_write_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axi-lite write master
// single register writes, aw and w accepted
// independently, counts open responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

`include "dma_ctrl_consts.svh"

module axil_write_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_req,
    input  dma_ctrl_pkg::reg_ofs_t   wr_ofs,
    input  dma_ctrl_pkg::axil_data_t wr_data,
    output logic                     wr_ready,
    output logic                     resp_idle,
    output logic                     awvalid,
    input  logic                     awready,
    output dma_ctrl_pkg::axil_addr_t awaddr,
    output logic                     wvalid,
    input  logic                     wready,
    output dma_ctrl_pkg::axil_data_t wdata,
    output logic [`DMA_STRB_W-1:0]   wstrb,
    input  logic                     bvalid,
    output logic                     bready
);

    import dma_ctrl_pkg::*;

    reg_ofs_t  ofs_q;
    resp_cnt_t out_cnt;
    logic      aw_hs;
    logic      w_hs;
    logic      wr_done;
    logic      b_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    // second of the two channels goes through this cycle
    assign wr_done = (aw_hs || w_hs) && (aw_hs || !awvalid) && (w_hs || !wvalid);
    assign b_hs    = bvalid && bready;

    assign wr_ready  = !awvalid && !wvalid;
    assign resp_idle = (out_cnt == '0);
    assign bready    = !resp_idle;
    assign awaddr    = axil_addr_t'(ofs_q);
    assign wstrb     = '1; // full word writes only

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (wr_req && wr_ready) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            if (aw_hs) begin
                awvalid <= 1'b0;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req && wr_ready) begin
            ofs_q <= wr_ofs;
            wdata <= wr_data;
        end
    end

    // open responses, up on a finished write, down on b
    always_ff @(posedge clk) begin
        if (rst) begin
            out_cnt <= '0;
        end else if (wr_done && !b_hs) begin
            out_cnt <= out_cnt + 1'b1;
        end else if (b_hs && !wr_done) begin
            out_cnt <= out_cnt - 1'b1;
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid);

    a_out_max: assert property (@(posedge clk) disable iff (rst)
        out_cnt <= resp_cnt_t'(`DMA_MAX_OUTSTANDING));

endmodule

// ==== design/chunk_walker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// chunk walker
// y inner, z outer, yields source and
// local addresses per chunk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

`include "dma_ctrl_consts.svh"

module chunk_walker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  logic                     step,
    input  dma_ctrl_pkg::axil_addr_t src_base,
    input  dma_ctrl_pkg::step_t      ett,
    input  dma_ctrl_pkg::step_t      y_step,
    input  dma_ctrl_pkg::step_t      y_lim,
    input  dma_ctrl_pkg::step_t      z_step,
    input  dma_ctrl_pkg::step_t      z_lim,
    output dma_ctrl_pkg::axil_addr_t src_addr,
    output dma_ctrl_pkg::axil_addr_t local_addr,
    output dma_ctrl_pkg::axil_data_t btt,
    output logic                     last_chunk
);

    import dma_ctrl_pkg::*;

    axil_addr_t base_q;
    step_t      ett_q;
    step_t      y_step_q;
    step_t      y_lim_q;
    step_t      z_step_q;
    step_t      z_lim_q;
    step_t      y_idx;
    step_t      z_idx;
    step_t      y_acc;
    step_t      z_acc;
    axil_addr_t local_ofs;

    // job settings, held for the whole walk
    always_ff @(posedge clk) begin
        if (load) begin
            base_q   <= src_base;
            ett_q    <= ett;
            y_step_q <= y_step;
            y_lim_q  <= y_lim;
            z_step_q <= z_step;
            z_lim_q  <= z_lim;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || load) begin
            y_idx     <= '0;
            z_idx     <= '0;
            y_acc     <= '0;
            z_acc     <= '0;
            local_ofs <= '0;
        end else if (step) begin
            local_ofs <= local_ofs + btt; // chunks packed back to back
            if (y_idx == y_lim_q) begin
                y_idx <= '0;
                y_acc <= '0;
                z_idx <= z_idx + 1'b1;
                z_acc <= z_acc + z_step_q;
            end else begin
                y_idx <= y_idx + 1'b1;
                y_acc <= y_acc + y_step_q;
            end
        end
    end

    assign btt        = axil_data_t'(ett_q) * `DMA_ELEM_BYTES;
    assign src_addr   = base_q + axil_addr_t'(y_acc) * `DMA_ELEM_BYTES
                      + axil_addr_t'(z_acc) * `DMA_ELEM_BYTES;
    assign local_addr = `DMA_LOCAL_WINDOW + local_ofs;
    assign last_chunk = (y_idx == y_lim_q) && (z_idx == z_lim_q);

    a_no_step_past_end: assert property (@(posedge clk) disable iff (rst)
        step |-> !last_chunk);

endmodule

// ==== design/dma_cmd_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma command FSM
// per-chunk register writes, interrupt
// wait and clear, job done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

`include "dma_ctrl_consts.svh"

module dma_cmd_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     dma_intr,
    input  logic                     wr_ready,
    input  logic                     resp_idle,
    input  dma_ctrl_pkg::axil_addr_t src_addr,
    input  dma_ctrl_pkg::axil_addr_t local_addr,
    input  dma_ctrl_pkg::axil_data_t btt,
    input  logic                     last_chunk,
    output logic                     wr_req,
    output dma_ctrl_pkg::reg_ofs_t   wr_ofs,
    output dma_ctrl_pkg::axil_data_t wr_data,
    output logic                     load,
    output logic                     step,
    output logic                     busy,
    output logic                     done
);

    import dma_ctrl_pkg::*;

    localparam axil_data_t MASK_DATA  = 32'd3; // reader and writer irq enable
    localparam axil_data_t START_DATA = 32'd3; // start reader and writer
    localparam axil_data_t CLEAR_DATA = 32'd1;

    seq_state_t state;
    logic [1:0] setup_idx;  // which of the four setup writes
    logic       wr_taken;
    logic       bus_idle;

    assign wr_taken = wr_req && wr_ready;
    // nothing presented and nothing in flight
    assign bus_idle = wr_ready && resp_idle;

    always_comb begin
        wr_req  = 1'b0;
        wr_ofs  = `DMA_MASK_OFS;
        wr_data = MASK_DATA;
        case (state)
            SEND_SETUP: begin
                wr_req = 1'b1;
                case (setup_idx)
                    2'd0: begin
                        wr_ofs  = `DMA_MASK_OFS;
                        wr_data = MASK_DATA;
                    end
                    2'd1: begin
                        wr_ofs  = `DMA_BTT_OFS;
                        wr_data = btt;
                    end
                    2'd2: begin
                        wr_ofs  = `DMA_RD_ADDR_OFS;
                        wr_data = axil_data_t'(src_addr);
                    end
                    default: begin
                        wr_ofs  = `DMA_WR_ADDR_OFS;
                        wr_data = axil_data_t'(local_addr);
                    end
                endcase
            end
            SEND_START: begin
                wr_req  = 1'b1;
                wr_ofs  = `DMA_CTRL_OFS;
                wr_data = START_DATA;
            end
            SEND_CLEAR: begin
                wr_req  = 1'b1;
                wr_ofs  = `DMA_STATUS_OFS;
                wr_data = CLEAR_DATA;
            end
            default: begin
                wr_req = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            setup_idx <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    setup_idx <= '0;
                    if (start) begin
                        state <= SEND_SETUP;
                    end
                end
                SEND_SETUP: begin
                    if (wr_taken) begin
                        setup_idx <= setup_idx + 1'b1; // wraps back to mask
                        if (setup_idx == 2'd3) begin
                            state <= SYNC_WRESP;
                        end
                    end
                end
                SYNC_WRESP: begin
                    if (bus_idle) begin
                        state <= SEND_START;
                    end
                end
                SEND_START: begin
                    if (wr_taken) begin
                        state <= WAIT_START_RESP;
                    end
                end
                WAIT_START_RESP: begin
                    if (bus_idle) begin
                        state <= WAIT_INTR;
                    end
                end
                WAIT_INTR: begin
                    if (dma_intr) begin
                        state <= SEND_CLEAR;
                    end
                end
                SEND_CLEAR: begin
                    if (wr_taken) begin
                        state <= WAIT_CLEAR_RESP;
                    end
                end
                WAIT_CLEAR_RESP: begin
                    if (bus_idle) begin
                        if (last_chunk) begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= NEXT_CHUNK;
                        end
                    end
                end
                NEXT_CHUNK: begin
                    state <= SEND_SETUP; // walker settles during this cycle
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign load = (state == IDLE) && start;
    assign step = (state == NEXT_CHUNK);
    assign busy = (state != IDLE);

endmodule

// ==== design/dma_ctrl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma command sequencer top
// FSM, chunk walker, axi-lite write master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

`include "dma_ctrl_consts.svh"

module dma_ctrl_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     dma_intr,
    input  dma_ctrl_pkg::axil_addr_t src_base,
    input  dma_ctrl_pkg::step_t      ett,
    input  dma_ctrl_pkg::step_t      y_step,
    input  dma_ctrl_pkg::step_t      y_lim,
    input  dma_ctrl_pkg::step_t      z_step,
    input  dma_ctrl_pkg::step_t      z_lim,
    output logic                     busy,
    output logic                     done,
    output logic                     awvalid,
    input  logic                     awready,
    output dma_ctrl_pkg::axil_addr_t awaddr,
    output logic                     wvalid,
    input  logic                     wready,
    output dma_ctrl_pkg::axil_data_t wdata,
    output logic [`DMA_STRB_W-1:0]   wstrb,
    input  logic                     bvalid,
    output logic                     bready
);

    import dma_ctrl_pkg::*;

    logic       wr_req;
    reg_ofs_t   wr_ofs;
    axil_data_t wr_data;
    logic       wr_ready;
    logic       resp_idle;
    logic       load;
    logic       step;
    axil_addr_t src_addr;
    axil_addr_t local_addr;
    axil_data_t btt;
    logic       last_chunk;

    dma_cmd_fsm dma_cmd_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .dma_intr   (dma_intr),
        .wr_ready   (wr_ready),
        .resp_idle  (resp_idle),
        .src_addr   (src_addr),
        .local_addr (local_addr),
        .btt        (btt),
        .last_chunk (last_chunk),
        .wr_req     (wr_req),
        .wr_ofs     (wr_ofs),
        .wr_data    (wr_data),
        .load       (load),
        .step       (step),
        .busy       (busy),
        .done       (done)
    );

    chunk_walker chunk_walker_inst (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .src_base   (src_base),
        .ett        (ett),
        .y_step     (y_step),
        .y_lim      (y_lim),
        .z_step     (z_step),
        .z_lim      (z_lim),
        .src_addr   (src_addr),
        .local_addr (local_addr),
        .btt        (btt),
        .last_chunk (last_chunk)
    );

    axil_write_master axil_write_master_inst (
        .clk       (clk),
        .rst       (rst),
        .wr_req    (wr_req),
        .wr_ofs    (wr_ofs),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .resp_idle (resp_idle),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

// ==== bench/dma_reg_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma engine register model
// axi-lite write slave with stalls, logs writes,
// raises the interrupt after a start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

`include "dma_ctrl_consts.svh"

module dma_reg_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall_en,
    input  logic [31:0]              rnd,
    input  logic                     awvalid,
    output logic                     awready,
    input  dma_ctrl_pkg::axil_addr_t awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  dma_ctrl_pkg::axil_data_t wdata,
    output logic                     bvalid,
    input  logic                     bready,
    output logic                     dma_intr
);

    import dma_ctrl_pkg::*;

    reg_ofs_t   log_ofs[$];
    axil_data_t log_data[$];
    resp_cnt_t  log_open[$];    // open responses as the write landed

    logic       aw_have = 1'b0;
    logic       w_have = 1'b0;
    reg_ofs_t   aw_ofs = '0;
    axil_data_t w_val = '0;
    resp_cnt_t  open_cnt = '0;
    logic       intr_q = 1'b0;
    logic       intr_armed = 1'b0;
    logic [4:0] intr_wait = '0;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic       wr_land;
    reg_ofs_t   land_ofs;
    axil_data_t land_data;

    // upper lcg bits, the low ones repeat too fast
    assign awready  = !aw_have && !(stall_en && rnd[31]);
    assign wready   = !w_have && !(stall_en && rnd[30]);
    assign bvalid   = (open_cnt != '0) && !(stall_en && rnd[29]);
    assign dma_intr = intr_q;

    assign aw_hs     = awvalid && awready;
    assign w_hs      = wvalid && wready;
    assign b_hs      = bvalid && bready;
    assign wr_land   = (aw_have || aw_hs) && (w_have || w_hs);
    assign land_ofs  = aw_have ? aw_ofs : reg_ofs_t'(awaddr);
    assign land_data = w_have ? w_val : wdata;

    always @(posedge clk) begin
        if (rst) begin
            aw_have    <= 1'b0;
            w_have     <= 1'b0;
            open_cnt   <= '0;
            intr_q     <= 1'b0;
            intr_armed <= 1'b0;
        end else begin
            if (wr_land) begin
                aw_have <= 1'b0;
                w_have  <= 1'b0;
                log_ofs.push_back(land_ofs);
                log_data.push_back(land_data);
                log_open.push_back(open_cnt);
            end else begin
                if (aw_hs) begin
                    aw_have <= 1'b1;
                    aw_ofs  <= reg_ofs_t'(awaddr);
                end
                if (w_hs) begin
                    w_have <= 1'b1;
                    w_val  <= wdata;
                end
            end
            if (wr_land && !b_hs) begin
                open_cnt <= open_cnt + 1'b1;
            end else if (b_hs && !wr_land) begin
                open_cnt <= open_cnt - 1'b1;
            end
            if (wr_land && land_ofs == `DMA_STATUS_OFS) begin
                intr_q <= 1'b0; // cleared by the status write
            end
            if (wr_land && land_ofs == `DMA_CTRL_OFS) begin
                intr_armed <= 1'b1;
                intr_wait  <= stall_en ? {1'b0, rnd[27:24]} + 5'd1 : 5'd2;
            end else if (intr_armed) begin
                if (intr_wait == '0) begin
                    intr_q     <= 1'b1;
                    intr_armed <= 1'b0;
                end else begin
                    intr_wait <= intr_wait - 1'b1;
                end
            end
        end
    end

endmodule

// ==== bench/tb_dma_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma sequencer testbench
// register write stream against a reference list
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

`include "dma_ctrl_consts.svh"

module tb_dma_ctrl;

    import dma_ctrl_pkg::*;

    localparam int CHUNK_WORST  = 300; // cycles per chunk, stalls included
    localparam int TOTAL_CHUNKS = 29;
    localparam int WATCHDOG_NS  = (TOTAL_CHUNKS * CHUNK_WORST + 200) * 4;

    logic        clk = 1'b0;
    logic [31:0] rnd = 32'd26467;
    logic        rst;
    logic        start;
    logic        stall_en;
    axil_addr_t  src_base;
    step_t       ett;
    step_t       y_step;
    step_t       y_lim;
    step_t       z_step;
    step_t       z_lim;
    logic        busy;
    logic        done;
    logic        dma_intr;
    logic        awvalid;
    logic        awready;
    axil_addr_t  awaddr;
    logic        wvalid;
    logic        wready;
    axil_data_t  wdata;
    logic [`DMA_STRB_W-1:0] wstrb;
    logic        bvalid;
    logic        bready;

    reg_ofs_t    exp_ofs[$];
    axil_data_t  exp_data[$];
    int          errs = 0;
    int          limit_errs = 0;
    int          checks = 0;
    int          test_cnt = 0;
    int          done_cnt = 0;
    int          mark;

    dma_ctrl_top dma_ctrl_top_inst (
        .clk(clk), .rst(rst), .start(start), .dma_intr(dma_intr),
        .src_base(src_base), .ett(ett), .y_step(y_step), .y_lim(y_lim),
        .z_step(z_step), .z_lim(z_lim), .busy(busy), .done(done),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready)
    );

    dma_reg_model reg_model_inst (
        .clk(clk), .rst(rst), .stall_en(stall_en), .rnd(rnd),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .dma_intr(dma_intr)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always #2 clk = ~clk;

    always @(posedge clk) begin
        rnd <= lcg_next(rnd);
    end

    always @(negedge clk) begin
        if (!rst && done) begin
            done_cnt <= done_cnt + 1;
        end
        if (!rst && reg_model_inst.open_cnt > resp_cnt_t'(`DMA_MAX_OUTSTANDING)) begin
            limit_errs <= limit_errs + 1;
            $display("[FAIL] %0t ns open responses at %0d, above the limit",
                     $time, reg_model_inst.open_cnt);
        end
        if (!rst && wvalid && wready) begin
            check_strb(wstrb, {`DMA_STRB_W{1'b1}}, "wstrb on a data beat"); // whole registers
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    function automatic void push_expected(input reg_ofs_t ofs, input axil_data_t data);
        exp_ofs.push_back(ofs);
        exp_data.push_back(data);
    endfunction

    // expected writes of a whole job, y inner, z outer
    function automatic void build_expected(input axil_addr_t base, input step_t e,
                                           input step_t ys, input step_t yl,
                                           input step_t zs, input step_t zl);
        axil_addr_t src;
        axil_addr_t dst;
        axil_data_t bytes;
        int         chunk;
        exp_ofs.delete();
        exp_data.delete();
        bytes = axil_data_t'(e) * `DMA_ELEM_BYTES;
        chunk = 0;
        for (int z = 0; z <= int'(zl); z++) begin
            for (int y = 0; y <= int'(yl); y++) begin
                src = base + axil_addr_t'(y) * axil_addr_t'(ys) * `DMA_ELEM_BYTES
                    + axil_addr_t'(z) * axil_addr_t'(zs) * `DMA_ELEM_BYTES;
                dst = `DMA_LOCAL_WINDOW + axil_addr_t'(chunk) * bytes;
                push_expected(`DMA_MASK_OFS, 32'd3);
                push_expected(`DMA_BTT_OFS, bytes);
                push_expected(`DMA_RD_ADDR_OFS, src);
                push_expected(`DMA_WR_ADDR_OFS, dst);
                push_expected(`DMA_CTRL_OFS, 32'd3);
                push_expected(`DMA_STATUS_OFS, 32'd1);
                chunk++;
            end
        end
    endfunction

    task automatic check_ofs(input reg_ofs_t got, input reg_ofs_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("[FAIL] %0t ns %s: got 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input axil_data_t got, input axil_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_cnt(input resp_cnt_t got, input resp_cnt_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(input logic [`DMA_STRB_W-1:0] got,
                              input logic [`DMA_STRB_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_log(input string name, input int log_base);
        int got_n;
        int n;
        got_n = reg_model_inst.log_ofs.size() - log_base;
        check_data(axil_data_t'(got_n), axil_data_t'(exp_ofs.size()), {name, " write count"});
        n = (got_n < exp_ofs.size()) ? got_n : exp_ofs.size();
        for (int i = 0; i < n; i++) begin
            check_ofs(reg_model_inst.log_ofs[log_base + i], exp_ofs[i],
                      $sformatf("%s write %0d offset", name, i));
            check_data(reg_model_inst.log_data[log_base + i], exp_data[i],
                       $sformatf("%s write %0d data", name, i));
            if (exp_ofs[i] == `DMA_CTRL_OFS) begin
                check_cnt(reg_model_inst.log_open[log_base + i], resp_cnt_t'(0),
                          $sformatf("%s write %0d open responses at start", name, i));
            end
        end
    endtask

    task automatic run_job(input string name, input axil_addr_t base, input step_t e,
                           input step_t ys, input step_t yl, input step_t zs,
                           input step_t zl, input logic stray, input logic stall);
        int log_base;
        int dones_before;
        int limit;
        int cycles;
        log_base     = reg_model_inst.log_ofs.size();
        dones_before = done_cnt;
        limit        = (int'(yl) + 1) * (int'(zl) + 1) * CHUNK_WORST;
        cycles       = 0;
        @(posedge clk);
        stall_en <= stall;
        src_base <= base;
        ett      <= e;
        y_step   <= ys;
        y_lim    <= yl;
        z_step   <= zs;
        z_lim    <= zl;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (stray) begin
            repeat (4) @(posedge clk);
            src_base <= base + 32'h0000_1000; // must not reach the walker
            start    <= 1'b1;
            @(posedge clk);
            start    <= 1'b0;
            src_base <= base;
        end
        @(negedge clk);
        check_bit(busy, 1'b1, {name, " busy during job"});
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errs++;
            $display("job %s gave no done pulse within %0d cycles", name, limit);
        end else begin
            repeat (8) @(negedge clk); // room for a second, wrong done
            check_data(axil_data_t'(done_cnt - dones_before), axil_data_t'(1),
                       {name, " done pulses"});
            check_bit(busy, 1'b0, {name, " busy after done"});
            build_expected(base, e, ys, yl, zs, zl);
            compare_log(name, log_base);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (errs == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, errs - errs_before);
        end
    endtask

    initial begin
        rst      = 1'b1;
        start    = 1'b0;
        stall_en = 1'b0;
        src_base = '0;
        ett      = '0;
        y_step   = '0;
        y_lim    = '0;
        z_step   = '0;
        z_lim    = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        mark = errs;
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_bit(awvalid, 1'b0, "awvalid after reset");
        check_bit(wvalid, 1'b0, "wvalid after reset");
        check_bit(bready, 1'b0, "bready after reset");
        report_test("reset_idle", mark);

        mark = errs;
        run_job("single", 32'h1000_0000, 24'd16, 24'd64, 24'd0, 24'd0, 24'd0, 1'b0, 1'b0);
        report_test("single_chunk", mark);

        mark = errs;
        run_job("walk", 32'h2000_0000, 24'd32, 24'd128, 24'd3, 24'd1024, 24'd2, 1'b0, 1'b0);
        report_test("yz_walk", mark);

        mark = errs;
        run_job("stall", 32'h2000_0000, 24'd32, 24'd128, 24'd3, 24'd1024, 24'd2, 1'b0, 1'b1);
        report_test("stalled_walk", mark);

        mark = errs;
        run_job("back_a", 32'h3000_0000, 24'd8, 24'd16, 24'd1, 24'd0, 24'd0, 1'b1, 1'b1);
        run_job("back_b", 32'h3800_0000, 24'd4, 24'd8, 24'd0, 24'd40, 24'd1, 1'b0, 1'b1);
        report_test("back_to_back", mark);

        errs = errs + limit_errs;
        $display("%0d tests, %0d checks, %0d errors", test_cnt, checks, errs);
        if (errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
design/dma_ctrl_pkg.sv
design/axil_write_master.sv
design/chunk_walker.sv
design/dma_cmd_fsm.sv
design/dma_ctrl_top.sv
bench/dma_reg_model.sv
bench/tb_dma_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the dma sequencer testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_dma_ctrl \
		-f project.f -Mdir obj_dir -o Vtb_dma_ctrl
	@out=$$(./obj_dir/Vtb_dma_ctrl); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
